//--- compile.f
+incdir+.
cpu_pkg.sv
reg_file.sv
idecoder.sv
alu.sv
branch_unit.sv
cpu_sequencer.sv
cpu.sv
tb_cpu.sv

//--- tb_cpu_model.svh
`ifndef tb_cpu_model_svh
`define tb_cpu_model_svh

// IO read data seen on any port.
function automatic data_t io_read_value(data_t port);
    return data_t'(port * 3 + 5);
endfunction

// Runs the program in flash on a software CPU.
// Fills the expected write queues and returns the halt address.
function automatic data_t run_model();
    data_t     regs [16];
    instr_u    w;
    data_t     pc;
    data_t     a;
    data_t     b;
    data_t     res;
    reg_addr_t dest;
    logic      carry;
    logic      zero;
    logic      c;
    logic      we;
    logic      upd;

    foreach (regs[i]) regs[i] = '0;
    pc = '0;
    carry = 1'b0;
    zero = 1'b0;
    model_halted = 1'b0;
    model_steps = 0;
    model_outs = 0;
    exp_port.delete();
    exp_val.delete();
    while (!model_halted && model_steps < 1000) begin
        w = flash[pc[7:0]];
        model_steps++;
        a = regs[w.r.src_a];
        b = regs[w.r.src_b];
        dest = w.r.dest;
        res = '0;
        c = 1'b0;
        we = 1'b1;
        upd = 1'b1;
        pc = pc + 1;
        case (w.r.opcode)
            op_add: {c, res} = a + b;
            op_sub: begin
                // Borrow is reported as carry.
                res = a - b;
                c = (a < b);
            end
            op_and: res = a & b;
            op_or:  res = a | b;
            op_xor: res = a ^ b;
            op_shl: begin
                res = a << 1;
                c = a[15];
            end
            op_shr: begin
                res = a >> 1;
                c = a[0];
            end
            default: begin
                // Immediate format, one register field.
                a = regs[w.i.rreg];
                dest = w.i.rreg;
                we = 1'b0;
                upd = 1'b0;
                case (w.i.opcode)
                    op_ldi: begin
                        res = w.i.imm;
                        we = 1'b1;
                    end
                    op_addi: begin
                        {c, res} = a + w.i.imm;
                        we = 1'b1;
                        upd = 1'b1;
                    end
                    op_in: begin
                        res = io_read_value(w.i.imm);
                        we = 1'b1;
                    end
                    op_out: begin
                        exp_port.push_back(w.i.imm);
                        exp_val.push_back(a);
                        model_outs++;
                    end
                    op_jmp: pc = w.i.imm;
                    op_jz:  if (zero) pc = w.i.imm;
                    op_jc:  if (carry) pc = w.i.imm;
                    op_hlt: begin
                        // Halt stays on its own word.
                        model_halted = 1'b1;
                        pc = pc - 1;
                    end
                    default: ;
                endcase
            end
        endcase
        if (we) regs[dest] = res;
        if (upd) begin
            carry = c;
            zero = (res == '0);
        end
    end
    return pc;
endfunction

`endif

//--- tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu
    import cpu_pkg::*;
();

    logic                   clk;
    logic                   reset;
    data_t                  address;
    logic [instr_width-1:0] data;
    logic                   rd;
    logic                   hlt;
    logic                   io_rd;
    logic                   io_wr;
    data_t                  io_addr;
    data_t                  io_wdata;
    data_t                  io_rdata;
    logic                   credit_return;

    // Flash contents and the expected results of the running test.
    logic [instr_width-1:0] flash [256];
    data_t                  exp_port [$];
    data_t                  exp_val [$];
    int                     model_steps;
    int                     model_outs;
    logic                   model_halted;
    string                  test_name = "none";
    int                     wp;
    // Credit return countdowns, one per write in flight.
    int                     pend_q [$];
    int                     cycle_count = 0;
    int                     cycle_limit = 100;

    `include "tb_cpu_model.svh"

    cpu #(.io_credits(2)) u_cpu (
        .clk(clk), .reset(reset), .address(address), .data(data),
        .rd(rd), .hlt(hlt), .io_rd(io_rd), .io_wr(io_wr),
        .io_addr(io_addr), .io_wdata(io_wdata), .io_rdata(io_rdata),
        .credit_return(credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // Failure reporting and checks
    // ------------------------------

    task automatic report_failure(string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_io_write(string name, data_t e_port, data_t e_val,
                                  data_t a_port, data_t a_val);
        if (e_port !== a_port) begin
            report_failure($sformatf("mismatch %s io port expected %h actual %h",
                                     name, e_port, a_port));
        end
        else if (e_val !== a_val) begin
            report_failure($sformatf("mismatch %s io data expected %h actual %h",
                                     name, e_val, a_val));
        end
    endtask

    task automatic check_halt(string name, data_t e_addr, data_t a_addr);
        if (e_addr !== a_addr) begin
            report_failure($sformatf("mismatch %s halt address expected %h actual %h",
                                     name, e_addr, a_addr));
        end
    endtask

    // ------------------------------
    // Flash, IO read and write queue
    // ------------------------------

    // Word shows up after the fetch cycle and holds through decode.
    always @(negedge clk) begin
        if (rd) data <= flash[address[7:0]];
    end

    always @(negedge clk) begin
        if (io_rd) io_rdata <= io_read_value(io_addr);
    end

    // Each write gets its credit back after 0 to 6 cycles, one return per cycle.
    initial begin : write_queue
        int ready;
        void'($urandom(32'haa3402b6));
        forever begin
            @(negedge clk);
            ready = -1;
            if (!reset) begin
                pend_q.delete();
                credit_return <= 1'b0;
            end
            else begin
                if (io_wr && pend_q.size() >= 2) begin
                    report_failure($sformatf("%s: io write issued with %0d writes outstanding",
                                             test_name, pend_q.size()));
                end
                foreach (pend_q[i]) begin
                    if (pend_q[i] == 0 && ready < 0) ready = i;
                    else if (pend_q[i] > 0) pend_q[i] = pend_q[i] - 1;
                end
                credit_return <= (ready >= 0);
                if (ready >= 0) pend_q.delete(ready);
                if (io_wr) pend_q.push_back($urandom_range(6, 0));
            end
        end
    end

    // Compare process, one expected entry per write.
    always @(negedge clk) begin : compare_writes
        data_t e_port;
        data_t e_val;
        if (reset && io_wr) begin
            if (exp_port.size() == 0) begin
                report_failure($sformatf("%s: io write to port %h when none was expected",
                                         test_name, io_addr));
            end
            else begin
                e_port = exp_port.pop_front();
                e_val = exp_val.pop_front();
                check_io_write(test_name, e_port, e_val, io_addr, io_wdata);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            report_failure($sformatf("timeout: cpu did not halt within %0d cycles",
                                     cycle_count));
        end
    end

    // ------------------------------
    // Program building
    // ------------------------------

    function automatic logic [instr_width-1:0] encode_reg(opcode_e op, reg_addr_t d,
                                                          reg_addr_t a, reg_addr_t b);
        instr_u w;
        w = '0;
        w.r.opcode = op;
        w.r.dest = d;
        w.r.src_a = a;
        w.r.src_b = b;
        return w;
    endfunction

    function automatic logic [instr_width-1:0] encode_imm(opcode_e op, reg_addr_t r,
                                                          data_t imm);
        instr_u w;
        w = '0;
        w.i.opcode = op;
        w.i.rreg = r;
        w.i.imm = imm;
        return w;
    endfunction

    task automatic emit(logic [instr_width-1:0] w);
        flash[wp] = w;
        wp++;
    endtask

    // Jump over the next word.
    task automatic emit_skip(opcode_e op);
        emit(encode_imm(op, 4'd0, data_t'(wp + 2)));
    endtask

    task automatic load_program(int prog);
        opcode_e alu_ops [7];
        alu_ops = '{op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr};
        // Unused words halt, each tagged with its own address.
        for (int i = 0; i < 256; i++) flash[i] = encode_imm(op_hlt, 4'd0, data_t'(i));
        wp = 0;
        case (prog)
            1: begin
                emit(encode_imm(op_ldi, 1, 16'h9a35));
                emit(encode_imm(op_ldi, 2, 16'h0ff0));
                for (int k = 0; k < 7; k++) begin
                    emit(encode_reg(alu_ops[k], 3, 1, 2));
                    emit(encode_imm(op_out, 3, data_t'(16'h10 + k)));
                end
                emit(encode_imm(op_addi, 1, 16'hf00d));
                emit(encode_imm(op_out, 1, 16'h0017));
            end
            2: begin
                emit(encode_imm(op_ldi, 1, 16'hffff));
                emit(encode_imm(op_ldi, 2, 16'h0001));
                emit(encode_imm(op_ldi, 5, 16'h00a1));
                emit(encode_imm(op_ldi, 6, 16'h00b2));
                // Overflow to zero, carry and zero both set.
                emit(encode_reg(op_add, 3, 1, 2));
                emit_skip(op_jc);
                emit(encode_imm(op_out, 6, 16'h0002));
                emit(encode_imm(op_out, 5, 16'h0001));
                // Clean add, both flags clear.
                emit(encode_reg(op_add, 3, 2, 2));
                emit_skip(op_jc);
                emit(encode_imm(op_out, 5, 16'h0003));
                emit_skip(op_jz);
                emit(encode_imm(op_out, 6, 16'h0004));
                emit(encode_reg(op_sub, 3, 2, 2));
                emit_skip(op_jz);
                emit(encode_imm(op_out, 6, 16'h0005));
                // Borrow.
                emit(encode_reg(op_sub, 3, 2, 1));
                emit_skip(op_jz);
                emit(encode_imm(op_out, 3, 16'h0006));
                emit_skip(op_jc);
                emit(encode_imm(op_out, 6, 16'h0007));
                emit_skip(op_jmp);
                emit(encode_imm(op_out, 6, 16'h0008));
            end
            3: begin
                emit(encode_imm(op_in, 1, 16'h0003));
                emit(encode_imm(op_out, 1, 16'h0030));
                emit(encode_imm(op_in, 2, 16'h0100));
                emit(encode_imm(op_out, 2, 16'h0031));
                emit(encode_imm(op_in, 3, 16'hffff));
                emit(encode_imm(op_out, 3, 16'h0032));
                emit(encode_reg(op_add, 4, 1, 2));
                emit(encode_imm(op_out, 4, 16'h0033));
            end
            default: begin
                for (int k = 1; k <= 8; k++) begin
                    emit(encode_imm(op_ldi, reg_addr_t'(k), data_t'(16'h1111 * k)));
                end
                // Eight OUTs back to back against two credits.
                for (int k = 1; k <= 8; k++) begin
                    emit(encode_imm(op_out, reg_addr_t'(k), data_t'(16'h40 + k)));
                end
                // Unknown opcode, runs as a no-op.
                emit('0);
            end
        endcase
        emit(encode_imm(op_hlt, 4'd0, 16'h0000));
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b0;
        repeat (10) @(negedge clk);
        if (rd || hlt || io_rd || io_wr || address !== '0) begin
            report_failure("cpu outputs were not idle at the end of reset");
        end
        reset = 1'b1;
    endtask

    task automatic run_test(string name, int prog);
        data_t halt_exp;
        load_program(prog);
        halt_exp = run_model();
        if (!model_halted) report_failure($sformatf("%s: reference never halts", name));
        cycle_limit = cycle_limit + 4 * (model_steps * 3 + model_outs * 6 * 2) + 60;
        test_name = name;
        apply_reset();
        while (!hlt) @(negedge clk);
        check_halt(name, halt_exp, address);
        if (exp_port.size() != 0) begin
            report_failure($sformatf("%s: cpu halted with %0d io writes missing",
                                     name, exp_port.size()));
        end
        // Stray writes during this window hit the compare process.
        repeat (50) begin
            @(negedge clk);
            if (!hlt) report_failure($sformatf("%s: hlt dropped after halt", name));
        end
        check_halt(name, halt_exp, address);
    endtask

    initial begin
        reset = 1'b0;
        data = '0;
        io_rdata = '0;
        credit_return = 1'b0;
        run_test("alu_ops", 1);
        run_test("flags_jumps", 2);
        run_test("io_read", 3);
        run_test("credit_burst", 4);
        // Same program again after a fresh reset.
        run_test("reset_rerun", 4);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- cpu.sv
`timescale 1ns/1ns

module cpu
    import cpu_pkg::*;
#(
    parameter int io_credits = 4
)
(
    input  logic                   clk,
    input  logic                   reset,
    // Flash port.
    output data_t                  address,
    input  logic [instr_width-1:0] data,
    output logic                   rd,
    output logic                   hlt,
    // IO port.
    output logic                   io_rd,
    output logic                   io_wr,
    output data_t                  io_addr,
    output data_t                  io_wdata,
    input  data_t                  io_rdata,
    input  logic                   credit_return
);

    logic [1:0] stage;
    decoded_t   ctrl;
    alu_flags_t flags;
    reg_addr_t  raddr_a, raddr_b, reg_waddr;
    data_t      rdata_a, rdata_b, reg_wdata;
    data_t      op_a, op_b, imm, alu_result, next_address;
    logic       reg_we;

    // ------------------------------
    // Datapath
    // ------------------------------

    reg_file u_reg_file (
        .clk(clk), .reset(reset),
        .raddr_a(raddr_a), .rdata_a(rdata_a),
        .raddr_b(raddr_b), .rdata_b(rdata_b),
        .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata)
    );

    idecoder u_idecoder (
        .clk(clk), .reset(reset), .stage(stage), .data(data),
        .raddr_a(raddr_a), .raddr_b(raddr_b),
        .rdata_a(rdata_a), .rdata_b(rdata_b),
        .ctrl(ctrl), .op_a(op_a), .op_b(op_b), .imm(imm)
    );

    alu u_alu (
        .clk(clk), .reset(reset), .stage(stage), .ctrl(ctrl),
        .op_a(op_a), .op_b(op_b), .result(alu_result), .flags(flags)
    );

    // Next address is worked out beside the ALU.
    branch_unit u_branch_unit (
        .address(address), .ctrl(ctrl), .flags(flags),
        .imm(imm), .next_address(next_address)
    );

    // ------------------------------
    // Control
    // ------------------------------

    cpu_sequencer #(.io_credits(io_credits)) u_cpu_sequencer (
        .clk(clk), .reset(reset), .ctrl(ctrl),
        .imm(imm), .op_a(op_a), .alu_result(alu_result),
        .next_address(next_address), .io_rdata(io_rdata),
        .credit_return(credit_return), .stage(stage), .address(address),
        .rd(rd), .io_rd(io_rd), .io_wr(io_wr), .hlt(hlt),
        .io_addr(io_addr), .io_wdata(io_wdata),
        .reg_we(reg_we), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata)
    );

endmodule

//--- cpu_sequencer.sv
`timescale 1ns/1ns

module cpu_sequencer
    import cpu_pkg::*;
#(
    parameter int io_credits = 4
)
(
    input  logic       clk,
    input  logic       reset,
    input  decoded_t   ctrl,
    input  data_t      imm,
    input  data_t      op_a,
    input  data_t      alu_result,
    input  data_t      next_address,
    input  data_t      io_rdata,
    input  logic       credit_return,
    output logic [1:0] stage,
    output data_t      address,
    output logic       rd,
    output logic       io_rd,
    output logic       io_wr,
    output logic       hlt,
    output data_t      io_addr,
    output data_t      io_wdata,
    output logic       reg_we,
    output reg_addr_t  reg_waddr,
    output logic [data_width-1:0] reg_wdata
);

    localparam int credit_width = $clog2(io_credits + 1);

    // Stage encoding. Boot is only seen right after reset.
    localparam logic [1:0] stage_fetch  = 2'd0;
    localparam logic [1:0] stage_decode = 2'd1;
    localparam logic [1:0] stage_exec   = 2'd2;
    localparam logic [1:0] stage_boot   = 2'd3;

    logic [credit_width-1:0] credit_cnt;
    logic                    exec_wait;
    logic                    exec_done;
    // Write-back pending from the last instruction.
    logic                    wb_pending;
    logic                    wb_from_io;
    data_t                   io_data_q;

    // OUT holds in execute until a credit is free.
    assign exec_wait = ctrl.is_io_wr && (credit_cnt == '0);
    assign exec_done = (stage == stage_exec) && !exec_wait;

    // ------------------------------
    // External strobes
    // ------------------------------

    assign rd       = (stage == stage_fetch) && !hlt;
    assign io_rd    = (stage == stage_decode) && ctrl.is_io_rd;
    // The write fires in the cycle that OUT leaves execute.
    assign io_wr    = exec_done && ctrl.is_io_wr;
    assign io_addr  = imm;
    assign io_wdata = op_a;

    // Write-back lands in the fetch stage of the next instruction.
    assign reg_we    = wb_pending;
    assign reg_wdata = wb_from_io ? io_data_q : alu_result;

    // ------------------------------
    // Stage counter and control state
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!reset) begin
            stage      <= stage_boot;
            address    <= '0;
            hlt        <= 1'b0;
            credit_cnt <= credit_width'(io_credits);
            wb_pending <= 1'b0;
            wb_from_io <= 1'b0;
        end
        else begin
            // One credit spent per write, one back per return pulse.
            credit_cnt <= credit_cnt + credit_width'(credit_return)
                                     - credit_width'(io_wr);
            if (!hlt) begin
                case (stage)
                    stage_boot:   stage <= stage_fetch;
                    stage_fetch: begin
                        stage      <= stage_decode;
                        wb_pending <= 1'b0;
                    end
                    stage_decode: stage <= stage_exec;
                    default: begin
                        if (!exec_wait) begin
                            stage      <= stage_fetch;
                            wb_pending <= ctrl.we;
                            wb_from_io <= ctrl.is_io_rd;
                            // Halt keeps the address on the HLT word.
                            if (ctrl.is_halt) begin
                                hlt <= 1'b1;
                            end
                            else begin
                                address <= next_address;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // Write-back payload.
    always_ff @(posedge clk) begin
        if (exec_done) begin
            reg_waddr <= ctrl.dest;
            io_data_q <= io_rdata;
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------

    // The queue never returns more credits than it was given.
    assert property (@(posedge clk) disable iff (!reset)
        credit_cnt <= credit_width'(io_credits))
        else $error("cpu_sequencer: credit count above io_credits");

    assert property (@(posedge clk) disable iff (!reset)
        io_wr |-> credit_cnt != '0)
        else $error("cpu_sequencer: io_wr without a credit");

    assert property (@(posedge clk) disable iff (!reset)
        !(io_rd && io_wr))
        else $error("cpu_sequencer: io_rd and io_wr together");

endmodule

//--- branch_unit.sv
`timescale 1ns/1ns

module branch_unit
    import cpu_pkg::*;
(
    // Address of the instruction now executing.
    input  data_t      address,
    input  decoded_t   ctrl,
    // Flags left by the previous flag-setting instruction.
    input  alu_flags_t flags,
    input  data_t      imm,
    output data_t      next_address
);

    logic taken;

    // ------------------------------
    // Branch condition
    // ------------------------------

    always_comb begin
        taken = 1'b0;
        if (ctrl.is_jump) begin
            case (ctrl.opcode)
                op_jmp:  taken = 1'b1;
                op_jz:   taken = flags.zero;
                op_jc:   taken = flags.carry;
                default: taken = 1'b0;
            endcase
        end
    end

    // Jump target is absolute.
    // Anything else steps to the next word.
    assign next_address = taken ? imm : address + data_t'(1);

    // Runs beside the ALU in the execute stage.
    // The sequencer only samples next_address at the end of stage 2.
    // Fetch and decode cycles may show a stale value here.

endmodule

//--- alu.sv
`timescale 1ns/1ns

module alu
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] stage,
    input  decoded_t   ctrl,
    input  data_t      op_a,
    input  data_t      op_b,
    output data_t      result,
    output alu_flags_t flags
);

    // One bit wider than a data word to catch the carry.
    logic [data_width:0] sum_w;
    logic [data_width:0] diff_w;
    data_t               res_c;
    logic                carry_c;

    assign sum_w  = {1'b0, op_a} + {1'b0, op_b};
    // Borrow shows up in the top bit.
    assign diff_w = {1'b0, op_a} - {1'b0, op_b};

    // ------------------------------
    // Combinational datapath
    // ------------------------------

    always_comb begin
        res_c   = '0;
        carry_c = 1'b0;
        case (ctrl.opcode)
            op_add, op_addi: begin
                res_c   = sum_w[data_width-1:0];
                carry_c = sum_w[data_width];
            end
            op_sub: begin
                res_c   = diff_w[data_width-1:0];
                carry_c = diff_w[data_width];
            end
            op_and: res_c = op_a & op_b;
            op_or:  res_c = op_a | op_b;
            op_xor: res_c = op_a ^ op_b;
            op_shl: begin
                // Bit shifted out goes to carry.
                res_c   = {op_a[data_width-2:0], 1'b0};
                carry_c = op_a[data_width-1];
            end
            op_shr: begin
                res_c   = {1'b0, op_a[data_width-1:1]};
                carry_c = op_a[0];
            end
            // Operand b already holds the immediate.
            op_ldi: res_c = op_b;
            default: ;
        endcase
    end

    // ------------------------------
    // Result and flag registers
    // ------------------------------

    // Result register, loaded every execute cycle.
    always_ff @(posedge clk) begin
        if (stage == 2'd2) begin
            result <= res_c;
        end
    end

    // Flags survive until the next flag-setting instruction.
    always_ff @(posedge clk) begin
        if (!reset) begin
            flags <= '0;
        end
        else if (stage == 2'd2 && ctrl.flag_en) begin
            flags.carry <= carry_c;
            flags.zero  <= (res_c == '0);
        end
    end

    // Zero flag agrees with the stored result after every update.
    property zero_tracks_result;
        @(posedge clk) disable iff (!reset)
        (stage == 2'd2 && ctrl.flag_en) |=> (flags.zero == (result == '0));
    endproperty

    assert property (zero_tracks_result)
        else $error("alu: zero flag does not match result");

endmodule

//--- idecoder.sv
`timescale 1ns/1ns

module idecoder
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [1:0]             stage,
    // Instruction word from the flash.
    input  logic [instr_width-1:0] data,
    // Register file read ports.
    output reg_addr_t              raddr_a,
    output reg_addr_t              raddr_b,
    input  data_t                  rdata_a,
    input  data_t                  rdata_b,
    // Decoded instruction.
    output decoded_t               ctrl,
    output data_t                  op_a,
    output data_t                  op_b,
    output data_t                  imm
);

    // Instruction latched at the end of the decode stage.
    instr_u  instr_q;
    // The word being decoded right now.
    instr_u  instr;
    opcode_e opcode;
    logic    is_reg_fmt;

    // ------------------------------
    // Instruction latch
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!reset) begin
            // Zero opcode decodes as a no-op.
            instr_q <= '0;
        end
        else if (stage == 2'd1) begin
            instr_q <= data;
        end
    end

    // Transparent during decode so that IO reads can start in stage 1.
    // Held from the latch during execute.
    assign instr  = (stage == 2'd1) ? instr_u'(data) : instr_q;
    assign opcode = instr.r.opcode;

    // Register-format instructions are the ALU register operations.
    assign is_reg_fmt = opcode inside {op_add, op_sub, op_and, op_or,
                                       op_xor, op_shl, op_shr};

    // ------------------------------
    // Operand selection
    // ------------------------------

    // Immediate format reads its one register field on port a.
    // Used as source for addi and out.
    assign raddr_a = is_reg_fmt ? instr.r.src_a : instr.i.rreg;
    assign raddr_b = is_reg_fmt ? instr.r.src_b : '0;
    assign imm     = is_reg_fmt ? '0 : instr.i.imm;

    assign op_a = rdata_a;
    assign op_b = ctrl.b_is_imm ? imm : rdata_b;

    // ------------------------------
    // Control struct
    // ------------------------------

    always_comb begin
        ctrl          = '0;
        ctrl.opcode   = opcode;
        ctrl.dest     = is_reg_fmt ? instr.r.dest : instr.i.rreg;
        case (opcode)
            op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr: begin
                ctrl.we      = 1'b1;
                ctrl.flag_en = 1'b1;
            end
            op_ldi: begin
                // Plain load, flags untouched.
                ctrl.we       = 1'b1;
                ctrl.b_is_imm = 1'b1;
            end
            op_addi: begin
                ctrl.we       = 1'b1;
                ctrl.flag_en  = 1'b1;
                ctrl.b_is_imm = 1'b1;
            end
            op_in: begin
                ctrl.we       = 1'b1;
                ctrl.is_io_rd = 1'b1;
            end
            op_out:                ctrl.is_io_wr = 1'b1;
            op_jmp, op_jz, op_jc:  ctrl.is_jump  = 1'b1;
            op_hlt:                ctrl.is_halt  = 1'b1;
            // Anything else runs as a no-op.
            default: ;
        endcase
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // Read port a.
    input  reg_addr_t raddr_a,
    output data_t     rdata_a,
    // Read port b.
    input  reg_addr_t raddr_b,
    output data_t     rdata_b,
    // Write port.
    input  logic      we,
    input  reg_addr_t waddr,
    input  data_t     wdata
);

    // Sixteen general registers.
    data_t regs [16];

    // Reads are combinational.
    // The decoder sees the operands in the same cycle it names them.
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // ------------------------------
    // Write port
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!reset) begin
            // All registers start at zero.
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end
        else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-back lands in the fetch stage, well before the next decode reads.
    // No read-during-write bypass is needed.

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    // Data word width. Addresses and IO port numbers use it too.
    parameter int data_width = 16;
    // One instruction word is two data words.
    parameter int instr_width = 2 * data_width;

    typedef logic [3:0] reg_addr_t;
    typedef logic [data_width-1:0] data_t;

    // ------------------------------
    // Opcodes
    // ------------------------------

    // Unlisted codes fall through the decoder as a no-op.
    typedef enum logic [7:0] {
        op_add  = 8'h01,
        op_sub  = 8'h02,
        op_and  = 8'h03,
        op_or   = 8'h04,
        op_xor  = 8'h05,
        op_shl  = 8'h06,
        op_shr  = 8'h07,
        op_ldi  = 8'h10,
        op_addi = 8'h11,
        op_in   = 8'h20,
        op_out  = 8'h21,
        op_jmp  = 8'h30,
        op_jz   = 8'h31,
        op_jc   = 8'h32,
        op_hlt  = 8'hff
    } opcode_e;

    // ------------------------------
    // Instruction formats
    // ------------------------------

    // Register format, dest <= src_a op src_b.
    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   dest;
        reg_addr_t   src_a;
        reg_addr_t   src_b;
        logic [11:0] unused;
    } instr_reg_t;

    // Immediate format. The register field is a destination or a source.
    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rreg;
        logic [3:0] unused;
        data_t      imm;
    } instr_imm_t;

    // Both views keep the opcode in the top byte.
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

    // ------------------------------
    // Control and status
    // ------------------------------

    typedef struct packed {
        logic carry;
        logic zero;
    } alu_flags_t;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t dest;
        logic      we;
        logic      flag_en;
        logic      b_is_imm;
        logic      is_io_rd;
        logic      is_io_wr;
        logic      is_jump;
        logic      is_halt;
    } decoded_t;

endpackage
